//--- rtl/addr_mode.sv
`default_nettype none

`include "cpu_consts.svh"

module addr_mode (
    input  cpu_pkg::state_t state,
    input  logic            cond,
    input  logic            db_sign,
    output cpu_pkg::ab_op_t ab_op
);

    cpu_pkg::ab_mode_t mode;
    logic [6:0]        op_high;
    logic [1:0]        op_abl;
    logic              back;

    assign back = cond & db_sign;   // Taken backward branch

    always_comb begin
        case (state)
            cpu_pkg::SYNC, cpu_pkg::IMM0,
            cpu_pkg::ABS0, cpu_pkg::IND0, cpu_pkg::JMP0: mode = `AB_MODE_INC;
            cpu_pkg::ABS1, cpu_pkg::IND1, cpu_pkg::JMP1: mode = `AB_MODE_ABS;
            cpu_pkg::ZERO, cpu_pkg::IDX0:                mode = `AB_MODE_ZP;
            cpu_pkg::BRK0, cpu_pkg::JSR0:                mode = `AB_MODE_PUSH_PC;
            cpu_pkg::BRK1, cpu_pkg::BRK2, cpu_pkg::JSR1: mode = `AB_MODE_STACK;
            cpu_pkg::DATA, cpu_pkg::JSR2:                mode = `AB_MODE_PC;
            cpu_pkg::PULL, cpu_pkg::RTS0, cpu_pkg::RTS1: mode = `AB_MODE_POP;
            cpu_pkg::BRK3: mode = `AB_MODE_VECTOR;
            cpu_pkg::COND: mode = `AB_MODE_BRANCH;
            cpu_pkg::IDX1: mode = `AB_MODE_INC_KEEP;
            cpu_pkg::IDX2: mode = `AB_MODE_IDX;
            cpu_pkg::PUSH: mode = `AB_MODE_PUSH;
            cpu_pkg::RTS2: mode = `AB_MODE_RTS;
            default:       mode = `AB_MODE_KEEP;   // RDWR
        endcase
    end

    always_comb begin
        op_high = '0;
        op_abl = '0;
        case (mode)
            `AB_MODE_KEEP: begin
                op_high = `AB_OP_HIGH_KEEP;
                op_abl = `AB_OP_ABL_AB;
            end
            `AB_MODE_PC: begin
                op_high = `AB_OP_HIGH_PC;
                op_abl = `AB_OP_ABL_PC;
            end
            `AB_MODE_ABS: begin
                op_high = `AB_OP_HIGH_ABS;
                op_abl = `AB_OP_ABL_REG;
            end
            `AB_MODE_ZP: begin
                op_high = `AB_OP_HIGH_ZP;
                op_abl = `AB_OP_ABL_REG;
            end
            `AB_MODE_INC: begin
                op_high = `AB_OP_HIGH_INC;
                op_abl = `AB_OP_ABL_AB;
            end
            `AB_MODE_POP: begin
                op_high = `AB_OP_HIGH_POP;
                op_abl = `AB_OP_ABL_SP;
            end
            `AB_MODE_BRANCH: begin
                op_high = back ? `AB_OP_HIGH_BACK : `AB_OP_HIGH_BRANCH;
                op_abl = `AB_OP_ABL_AB;
            end
            `AB_MODE_STACK: begin
                op_high = `AB_OP_HIGH_STACK;
                op_abl = `AB_OP_ABL_SP;
            end
            `AB_MODE_PUSH_PC: begin
                op_high = `AB_OP_HIGH_PUSH_PC;
                op_abl = `AB_OP_ABL_SP;
            end
            `AB_MODE_IDX: begin
                op_high = `AB_OP_HIGH_IDX;
                op_abl = `AB_OP_ABL_REG;
            end
            `AB_MODE_PUSH: begin
                op_high = `AB_OP_HIGH_PUSH;
                op_abl = `AB_OP_ABL_SP;
            end
            `AB_MODE_INC_KEEP: begin
                op_high = `AB_OP_HIGH_INC_KEEP;
                op_abl = `AB_OP_ABL_AB;
            end
            `AB_MODE_RTS: begin
                op_high = `AB_OP_HIGH_RTS;
                op_abl = `AB_OP_ABL_REG;
            end
            `AB_MODE_VECTOR: begin
                op_high = `AB_OP_HIGH_VECTOR;
                op_abl = `AB_OP_ABL_SP;
            end
            default: ;   // Modes 6 and 13 unused
        endcase
    end

    // Mode bits 1:0 pick the ABL mux, bit 2 is the ABL carry in
    assign ab_op = {op_high, mode[1:0], op_abl, mode[2]};

endmodule

`default_nettype wire

//--- rtl/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Control word field positions
`define CW_SRC_LSB      0
`define CW_SRC_MSB      3
`define CW_DST_LSB      4
`define CW_DST_MSB      5
`define CW_LD_BIT       6
`define CW_ALU_LSB      7
`define CW_ALU_MSB      13
`define CW_ST_BIT       14
`define CW_RMW_BIT      15
`define CW_ADDX_BIT     16
`define CW_ADDY_BIT     17
`define CW_FLAG_LSB     18
`define CW_FLAG_MSB     27
`define CW_PHP_BIT      28

// Register file codes
`define SRC_X           4'b0000
`define SRC_Y           4'b0001
`define SRC_S           4'b0011
`define SRC_Z           4'b0111
`define SRC_RST_VEC     4'b1001
`define SRC_BRK_VEC     4'b1010
`define DST_S           2'b11

// Address path modes
`define AB_MODE_KEEP     4'd0
`define AB_MODE_PC       4'd1
`define AB_MODE_ABS      4'd2
`define AB_MODE_ZP       4'd3
`define AB_MODE_INC      4'd4
`define AB_MODE_POP      4'd5
`define AB_MODE_BRANCH   4'd7
`define AB_MODE_STACK    4'd8
`define AB_MODE_PUSH_PC  4'd9
`define AB_MODE_IDX      4'd10
`define AB_MODE_PUSH     4'd11
`define AB_MODE_INC_KEEP 4'd12
`define AB_MODE_RTS      4'd14
`define AB_MODE_VECTOR   4'd15

// PC, AHL and ABH controls per mode
`define AB_OP_HIGH_KEEP     7'b001_0110
`define AB_OP_HIGH_PC       7'b000_1010
`define AB_OP_HIGH_ABS      7'b111_1110
`define AB_OP_HIGH_ZP       7'b111_0000
`define AB_OP_HIGH_INC      7'b011_0110
`define AB_OP_HIGH_POP      7'b011_0001
`define AB_OP_HIGH_BRANCH   7'b011_0110
`define AB_OP_HIGH_BACK     7'b011_0111
`define AB_OP_HIGH_STACK    7'b000_0001
`define AB_OP_HIGH_PUSH_PC  7'b111_0001
`define AB_OP_HIGH_IDX      7'b001_1110
`define AB_OP_HIGH_PUSH     7'b010_0001
`define AB_OP_HIGH_INC_KEEP 7'b001_0110
`define AB_OP_HIGH_RTS      7'b001_1110
`define AB_OP_HIGH_VECTOR   7'b000_0011

// Low byte operand source
`define AB_OP_ABL_SP    2'b00
`define AB_OP_ABL_REG   2'b01
`define AB_OP_ABL_PC    2'b10
`define AB_OP_ABL_AB    2'b11

// Data output selects
`define DO_ALU          2'b00
`define DO_P            2'b01
`define DO_PCL          2'b10
`define DO_PCH          2'b11

// Fixed ALU operations
`define ALU_DEC         9'b00_00_101_00
`define ALU_INC         9'b00_00_100_01
`define ALU_LDM         9'b10_00_000_00
`define ALU_PASS        9'b00_00_100_00

`endif

//--- rtl/cpu_ctl.sv
`default_nettype none

`include "cpu_consts.svh"

module cpu_ctl (
    input  logic              clk,
    input  logic              reset,
    input  cpu_pkg::opcode_t  db,
    input  logic              cond,
    output logic              sync,
    output logic              we,
    output cpu_pkg::flag_op_t flag_op,
    output cpu_pkg::alu_op_t  alu_op,
    output cpu_pkg::reg_op_t  reg_op,
    output cpu_pkg::do_sel_t  do_op,
    output cpu_pkg::ab_op_t   ab_op
);

    cpu_pkg::state_t    entry_state;
    cpu_pkg::state_t    state;
    cpu_pkg::ctl_word_t cw;
    logic               reset_entry;

    opcode_decode u_decode (
        .clk         (clk),
        .reset       (reset),
        .sync        (sync),
        .db          (db),
        .entry_state (entry_state),
        .cw          (cw),
        .flag_op     (flag_op)
    );

    exec_fsm u_fsm (
        .clk         (clk),
        .reset       (reset),
        .entry_state (entry_state),
        .rmw         (cw[`CW_RMW_BIT]),
        .state       (state),
        .sync        (sync),
        .reset_entry (reset_entry)
    );

    addr_mode u_addr (
        .state   (state),
        .cond    (cond),
        .db_sign (db[7]),   // Branch offset sign
        .ab_op   (ab_op)
    );

    micro_ops u_ops (
        .clk         (clk),
        .reset       (reset),
        .state       (state),
        .cw          (cw),
        .reset_entry (reset_entry),
        .we          (we),
        .reg_op      (reg_op),
        .alu_op      (alu_op),
        .do_op       (do_op)
    );

endmodule

`default_nettype wire

//--- rtl/cpu_pkg.sv
`default_nettype none

`include "cpu_consts.svh"

package cpu_pkg;

    typedef enum logic [4:0] {
        BRK0 = 5'b00000,
        JSR0 = 5'b00001,
        RTS0 = 5'b00011,
        IDX1 = 5'b00100,
        IDX2 = 5'b00101,
        RDWR = 5'b00110,
        RTS1 = 5'b00111,
        ZERO = 5'b01000,
        ABS0 = 5'b01001,
        JMP0 = 5'b01010,
        IND0 = 5'b01011,
        ABS1 = 5'b01100,
        JSR1 = 5'b01101,
        JSR2 = 5'b01110,
        BRK1 = 5'b01111,
        IMM0 = 5'b10000,
        PULL = 5'b10010,
        PUSH = 5'b10011,
        DATA = 5'b10100,
        BRK2 = 5'b10101,
        BRK3 = 5'b10110,
        SYNC = 5'b11000,
        COND = 5'b11001,
        IDX0 = 5'b11010,
        JMP1 = 5'b11101,
        IND1 = 5'b11110,
        RTS2 = 5'b11111
    } state_t;

    typedef logic [7:0]            opcode_t;
    typedef logic [`CW_PHP_BIT:0]  ctl_word_t;   // php, flags, YX, MS, alu, W, dst, src
    typedef logic [9:0]            flag_op_t;
    typedef logic [8:0]            alu_op_t;     // ldm, bcd, shift, add, carry
    typedef logic [6:0]            reg_op_t;     // W, dst, src
    typedef logic [3:0]            ab_mode_t;
    typedef logic [11:0]           ab_op_t;
    typedef logic [1:0]            do_sel_t;     // ALU, P, PCL, PCH

endpackage

`default_nettype wire

//--- rtl/exec_fsm.sv
`default_nettype none

`include "cpu_consts.svh"

module exec_fsm (
    input  logic            clk,
    input  logic            reset,
    input  cpu_pkg::state_t entry_state,
    input  logic            rmw,
    output cpu_pkg::state_t state,
    output logic            sync,
    output logic            reset_entry
);

    cpu_pkg::state_t state_next;
    logic            state_ok;

    always_comb begin
        state_ok = 1'b1;
        case (state)
            cpu_pkg::SYNC: state_next = reset_entry ? cpu_pkg::BRK0 : entry_state;
            cpu_pkg::ABS0: state_next = cpu_pkg::ABS1;
            cpu_pkg::ABS1: state_next = rmw ? cpu_pkg::RDWR : cpu_pkg::DATA;
            cpu_pkg::ZERO: state_next = rmw ? cpu_pkg::RDWR : cpu_pkg::DATA;
            cpu_pkg::RDWR: state_next = cpu_pkg::DATA;
            cpu_pkg::DATA: state_next = cpu_pkg::SYNC;
            cpu_pkg::IMM0: state_next = cpu_pkg::SYNC;
            cpu_pkg::COND: state_next = cpu_pkg::SYNC;
            cpu_pkg::IDX0: state_next = cpu_pkg::IDX1;
            cpu_pkg::IDX1: state_next = cpu_pkg::IDX2;
            cpu_pkg::IDX2: state_next = cpu_pkg::DATA;
            cpu_pkg::BRK0: state_next = cpu_pkg::BRK1;
            cpu_pkg::BRK1: state_next = cpu_pkg::BRK2;
            cpu_pkg::BRK2: state_next = cpu_pkg::BRK3;
            cpu_pkg::BRK3: state_next = cpu_pkg::JMP0;   // Vector fetch
            cpu_pkg::IND0: state_next = cpu_pkg::IND1;
            cpu_pkg::IND1: state_next = cpu_pkg::JMP0;
            cpu_pkg::JMP0: state_next = cpu_pkg::JMP1;
            cpu_pkg::JMP1: state_next = cpu_pkg::SYNC;
            cpu_pkg::JSR0: state_next = cpu_pkg::JSR1;
            cpu_pkg::JSR1: state_next = cpu_pkg::JSR2;
            cpu_pkg::JSR2: state_next = cpu_pkg::JMP1;
            cpu_pkg::RTS0: state_next = cpu_pkg::RTS1;
            cpu_pkg::RTS1: state_next = cpu_pkg::RTS2;
            cpu_pkg::RTS2: state_next = cpu_pkg::SYNC;
            cpu_pkg::PUSH: state_next = cpu_pkg::DATA;
            cpu_pkg::PULL: state_next = cpu_pkg::DATA;
            default: begin
                state_next = cpu_pkg::SYNC;
                state_ok = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= cpu_pkg::SYNC;
            reset_entry <= 1'b1;
        end else begin
            state <= state_next;
            if (state == cpu_pkg::BRK3) begin
                reset_entry <= 1'b0;   // Reset vector taken
            end
        end
    end

    assign sync = (state == cpu_pkg::SYNC);

    a_state_legal: assert property (@(posedge clk) disable iff (reset) state_ok);

    // BRK3, JMP0, JMP1, then a normal sync
    a_reset_entry_done: assert property (@(posedge clk) disable iff (reset)
        (state == cpu_pkg::BRK3) |-> ##3 (sync && !reset_entry));

endmodule

`default_nettype wire

//--- rtl/micro_ops.sv
`default_nettype none

`include "cpu_consts.svh"

module micro_ops (
    input  logic               clk,
    input  logic               reset,
    input  cpu_pkg::state_t    state,
    input  cpu_pkg::ctl_word_t cw,
    input  logic               reset_entry,
    output logic               we,
    output cpu_pkg::reg_op_t   reg_op,
    output cpu_pkg::alu_op_t   alu_op,
    output cpu_pkg::do_sel_t   do_op
);

    logic       ld;
    logic       st;
    logic       rmw;
    logic       add_x;
    logic       add_y;
    logic       php;
    logic [1:0] dst;
    logic [3:0] src;
    logic [6:0] alu;
    logic [3:0] idx_src;

    assign src = cw[`CW_SRC_MSB:`CW_SRC_LSB];
    assign dst = cw[`CW_DST_MSB:`CW_DST_LSB];
    assign alu = cw[`CW_ALU_MSB:`CW_ALU_LSB];
    assign ld = cw[`CW_LD_BIT];
    assign st = cw[`CW_ST_BIT];
    assign rmw = cw[`CW_RMW_BIT];
    assign add_x = cw[`CW_ADDX_BIT];
    assign add_y = cw[`CW_ADDY_BIT];
    assign php = cw[`CW_PHP_BIT];

    // Index register for ZERO, ABS1 and IND1
    assign idx_src = add_x ? `SRC_X : (add_y ? `SRC_Y : `SRC_Z);

    // Register operation W, dst, src
    always_comb begin
        case (state)
            cpu_pkg::BRK0, cpu_pkg::BRK1, cpu_pkg::BRK2, cpu_pkg::JSR0, cpu_pkg::JSR1,
            cpu_pkg::RTS0, cpu_pkg::RTS1, cpu_pkg::PUSH, cpu_pkg::PULL:
                reg_op = {1'b1, `DST_S, `SRC_S};   // Stack pointer update
            cpu_pkg::BRK3:
                reg_op = {3'b000, reset_entry ? `SRC_RST_VEC : `SRC_BRK_VEC};
            cpu_pkg::RTS2, cpu_pkg::JMP1:
                reg_op = {3'b000, `SRC_Z};
            cpu_pkg::IDX0:
                reg_op = {3'b000, add_x ? `SRC_X : `SRC_Z};
            cpu_pkg::IDX2:
                reg_op = {3'b000, add_y ? `SRC_Y : `SRC_Z};
            cpu_pkg::ZERO, cpu_pkg::ABS1, cpu_pkg::IND1:
                reg_op = {3'b000, idx_src};
            cpu_pkg::SYNC:
                reg_op = {ld, dst, src};   // Finish previous opcode
            cpu_pkg::DATA:
                reg_op = {1'b0, dst, src};
            default:
                reg_op = '0;
        endcase
    end

    always_comb begin
        case (state)
            cpu_pkg::BRK0, cpu_pkg::BRK1, cpu_pkg::BRK2,
            cpu_pkg::JSR0, cpu_pkg::JSR1, cpu_pkg::PUSH:
                alu_op = `ALU_DEC;
            cpu_pkg::RTS0, cpu_pkg::RTS1, cpu_pkg::PULL:
                alu_op = `ALU_INC;
            cpu_pkg::IMM0, cpu_pkg::RDWR:
                alu_op = `ALU_LDM;
            cpu_pkg::SYNC:
                alu_op = {2'b10, alu};
            cpu_pkg::DATA:
                if (st) begin
                    alu_op = `ALU_PASS;   // Store register to M
                end else if (rmw) begin
                    alu_op = {2'b00, alu};
                end else begin
                    alu_op = {2'b10, alu};
                end
            default:
                alu_op = '0;
        endcase
    end

    always_comb begin
        case (state)
            cpu_pkg::BRK1, cpu_pkg::JSR1: do_op = `DO_PCH;
            cpu_pkg::BRK2, cpu_pkg::JSR2: do_op = `DO_PCL;
            cpu_pkg::BRK3:                do_op = `DO_P;
            cpu_pkg::DATA:                do_op = php ? `DO_P : `DO_ALU;
            default:                      do_op = `DO_ALU;
        endcase
    end

    // Write strobe lands one cycle after the writing state
    always_ff @(posedge clk) begin
        if (reset) begin
            we <= 1'b0;
        end else begin
            case (state)
                cpu_pkg::BRK0, cpu_pkg::BRK1, cpu_pkg::BRK2, cpu_pkg::JSR0,
                cpu_pkg::JSR1, cpu_pkg::PUSH, cpu_pkg::RDWR:
                    we <= 1'b1;
                cpu_pkg::ABS1, cpu_pkg::ZERO:
                    we <= st;
                default:
                    we <= 1'b0;
            endcase
        end
    end

    // Opcode fetch cycle never writes memory
    a_no_we_after_sync: assert property (@(posedge clk) disable iff (reset)
        (state == cpu_pkg::SYNC) |=> !we);

endmodule

`default_nettype wire

//--- rtl/opcode_decode.sv
`default_nettype none

`include "cpu_consts.svh"

module opcode_decode (
    input  logic               clk,
    input  logic               reset,
    input  logic               sync,
    input  cpu_pkg::opcode_t   db,
    output cpu_pkg::state_t    entry_state,
    output cpu_pkg::ctl_word_t cw,
    output cpu_pkg::flag_op_t  flag_op
);

    cpu_pkg::ctl_word_t cw_next;
    logic               known;

    // Columns: P flags YX MS <> ADD CI W DR SRC
    always_comb begin
        known = 1'b1;
        case (db)
            8'h48:                      cw_next = 29'b0_0000000000_00_00_00_100_00_0_00_0010; // PHA
            8'hA9, 8'hA5, 8'hAD, 8'h68: cw_next = 29'b0_1000011000_00_00_00_000_00_1_10_0111; // LDA PLA
            8'hA2, 8'hA6, 8'hAE:        cw_next = 29'b0_1000011000_00_00_00_000_00_1_00_0111; // LDX
            8'hA0, 8'hA4, 8'hAC:        cw_next = 29'b0_1000011000_00_00_00_000_00_1_01_0111; // LDY
            8'h85, 8'h8D:               cw_next = 29'b0_0000000000_00_01_00_100_00_0_00_0010; // STA
            8'h86, 8'h8E:               cw_next = 29'b0_0000000000_00_01_00_100_00_0_00_0000; // STX
            8'h84, 8'h8C:               cw_next = 29'b0_0000000000_00_01_00_100_00_0_00_0001; // STY
            8'h09, 8'h05, 8'h0D:        cw_next = 29'b0_1000011000_00_00_00_000_00_1_10_0010; // ORA
            8'h11:                      cw_next = 29'b0_1000011000_10_00_00_000_00_1_10_0010;
            8'h29, 8'h25, 8'h2D:        cw_next = 29'b0_1000011000_00_00_00_001_00_1_10_0010; // AND
            8'h31:                      cw_next = 29'b0_1000011000_10_00_00_001_00_1_10_0010;
            8'h49, 8'h45, 8'h4D:        cw_next = 29'b0_1000011000_00_00_00_010_00_1_10_0010; // EOR
            8'h51:                      cw_next = 29'b0_1000011000_10_00_00_010_00_1_10_0010;
            8'h69, 8'h65, 8'h6D:        cw_next = 29'b0_1010011011_00_00_00_011_11_1_10_0010; // ADC
            8'h71:                      cw_next = 29'b0_1010011011_10_00_00_011_11_1_10_0010;
            8'hE9, 8'hE5, 8'hED:        cw_next = 29'b0_1010011011_00_00_00_110_11_1_10_0010; // SBC
            8'hF1:                      cw_next = 29'b0_1010011011_10_00_00_110_11_1_10_0010;
            8'hC9, 8'hC5, 8'hCD:        cw_next = 29'b0_1000011011_00_00_00_110_01_0_00_0010; // CMP
            8'hD1:                      cw_next = 29'b0_1000011011_10_00_00_110_01_0_00_0010;
            8'hE6, 8'hEE:               cw_next = 29'b0_1000011000_00_10_00_011_00_0_00_0101; // INC
            8'hC6, 8'hCE:               cw_next = 29'b0_1000011000_00_10_00_011_00_0_00_0110; // DEC
            8'h06, 8'h0E:               cw_next = 29'b0_1000011011_00_10_10_000_00_0_00_0111; // ASL
            8'h18:                      cw_next = 29'b0_0000000011_00_00_00_000_00_0_00_0111; // CLC
            8'h38:                      cw_next = 29'b0_0000000011_00_00_00_101_01_0_00_0111; // SEC
            // Control flow and NOP carry an empty word
            8'h00, 8'h20, 8'h60, 8'h4C, 8'h6C, 8'h80, 8'hEA,
            8'h10, 8'h30, 8'h50, 8'h70, 8'h90, 8'hB0, 8'hD0, 8'hF0: cw_next = '0;
            default: begin
                cw_next = '0;
                known = 1'b0;
            end
        endcase
    end

    // Entry state by opcode column, kept opcodes only
    always_comb begin
        entry_state = cpu_pkg::SYNC;
        if (known) begin
            casez (db)
                8'b0000_0000: entry_state = cpu_pkg::BRK0;
                8'b0010_0000: entry_state = cpu_pkg::JSR0;
                8'b0110_0000: entry_state = cpu_pkg::RTS0;
                8'b0110_1000: entry_state = cpu_pkg::PULL;   // PLA
                8'b0100_1000: entry_state = cpu_pkg::PUSH;   // PHA
                8'b1000_0000: entry_state = cpu_pkg::COND;   // BRA
                8'b???1_0000: entry_state = cpu_pkg::COND;
                8'b???1_0001: entry_state = cpu_pkg::IDX0;   // (zp),Y
                8'b1010_00?0: entry_state = cpu_pkg::IMM0;   // LDY# LDX#
                8'b???0_1001: entry_state = cpu_pkg::IMM0;
                8'b0110_1100: entry_state = cpu_pkg::IND0;
                8'b0100_1100: entry_state = cpu_pkg::JMP0;
                8'b????_11??: entry_state = cpu_pkg::ABS0;
                8'b????_01??: entry_state = cpu_pkg::ZERO;
                default:      entry_state = cpu_pkg::SYNC;   // NOP, CLC, SEC
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cw <= '0;
        end else if (sync) begin
            cw <= cw_next;
        end
    end

    assign flag_op = cw[`CW_FLAG_MSB:`CW_FLAG_LSB];

    // The latched word must be fully known once an opcode is taken
    a_cw_known: assert property (@(posedge clk) disable iff (reset)
        sync |=> !$isunknown(cw));

endmodule

`default_nettype wire

//--- tb/cpu_ctl_vectors.svh
`ifndef CPU_CTL_VECTORS_SVH
`define CPU_CTL_VECTORS_SVH

typedef enum logic [1:0] {
    K_PLAIN,
    K_BRANCH,
    K_JSR,
    K_BRK
} kind_t;

typedef struct packed {
    cpu_pkg::opcode_t  op;
    logic [3:0]        cycles;     // Sync to sync
    logic [1:0]        writes;     // We cycles in between
    kind_t             kind;
    cpu_pkg::reg_op_t  exp_reg;    // At the following sync
    cpu_pkg::alu_op_t  exp_alu;
    cpu_pkg::flag_op_t exp_flag;
} vector_t;

localparam int NUM_VECTORS = 58;

// Columns: opcode, cycles, writes, kind, then reg_op, alu_op and flag_op seen at the next sync
localparam vector_t VECTORS [NUM_VECTORS] = '{
    '{8'hA9, 4'd2, 2'd0, K_PLAIN,  7'b1_10_0111, 9'b10_00_000_00, 10'b10000_11000},
    '{8'hA5, 4'd3, 2'd0, K_PLAIN,  7'b1_10_0111, 9'b10_00_000_00, 10'b10000_11000},
    '{8'hAD, 4'd4, 2'd0, K_PLAIN,  7'b1_10_0111, 9'b10_00_000_00, 10'b10000_11000},
    '{8'hA2, 4'd2, 2'd0, K_PLAIN,  7'b1_00_0111, 9'b10_00_000_00, 10'b10000_11000},
    '{8'hAE, 4'd4, 2'd0, K_PLAIN,  7'b1_00_0111, 9'b10_00_000_00, 10'b10000_11000},
    '{8'hA0, 4'd2, 2'd0, K_PLAIN,  7'b1_01_0111, 9'b10_00_000_00, 10'b10000_11000},
    '{8'hA4, 4'd3, 2'd0, K_PLAIN,  7'b1_01_0111, 9'b10_00_000_00, 10'b10000_11000},
    '{8'h85, 4'd3, 2'd1, K_PLAIN,  7'b0_00_0010, 9'b10_00_100_00, 10'b00000_00000},
    '{8'h8D, 4'd4, 2'd1, K_PLAIN,  7'b0_00_0010, 9'b10_00_100_00, 10'b00000_00000},
    '{8'h86, 4'd3, 2'd1, K_PLAIN,  7'b0_00_0000, 9'b10_00_100_00, 10'b00000_00000},
    '{8'h8C, 4'd4, 2'd1, K_PLAIN,  7'b0_00_0001, 9'b10_00_100_00, 10'b00000_00000},
    '{8'h10, 4'd2, 2'd0, K_BRANCH, 7'b0_00_0000, 9'b10_00_000_00, 10'b00000_00000},
    '{8'h09, 4'd2, 2'd0, K_PLAIN,  7'b1_10_0010, 9'b10_00_000_00, 10'b10000_11000},
    '{8'h2D, 4'd4, 2'd0, K_PLAIN,  7'b1_10_0010, 9'b10_00_001_00, 10'b10000_11000},
    '{8'h45, 4'd3, 2'd0, K_PLAIN,  7'b1_10_0010, 9'b10_00_010_00, 10'b10000_11000},
    '{8'h51, 4'd5, 2'd0, K_PLAIN,  7'b1_10_0010, 9'b10_00_010_00, 10'b10000_11000},
    '{8'h11, 4'd5, 2'd0, K_PLAIN,  7'b1_10_0010, 9'b10_00_000_00, 10'b10000_11000},
    '{8'h31, 4'd5, 2'd0, K_PLAIN,  7'b1_10_0010, 9'b10_00_001_00, 10'b10000_11000},
    '{8'h69, 4'd2, 2'd0, K_PLAIN,  7'b1_10_0010, 9'b10_00_011_11, 10'b10100_11011},
    '{8'h71, 4'd5, 2'd0, K_PLAIN,  7'b1_10_0010, 9'b10_00_011_11, 10'b10100_11011},
    '{8'hE9, 4'd2, 2'd0, K_PLAIN,  7'b1_10_0010, 9'b10_00_110_11, 10'b10100_11011},
    '{8'hF1, 4'd5, 2'd0, K_PLAIN,  7'b1_10_0010, 9'b10_00_110_11, 10'b10100_11011},
    '{8'hC9, 4'd2, 2'd0, K_PLAIN,  7'b0_00_0010, 9'b10_00_110_01, 10'b10000_11011},
    '{8'hCD, 4'd4, 2'd0, K_PLAIN,  7'b0_00_0010, 9'b10_00_110_01, 10'b10000_11011},
    '{8'hD1, 4'd5, 2'd0, K_PLAIN,  7'b0_00_0010, 9'b10_00_110_01, 10'b10000_11011},
    '{8'h30, 4'd2, 2'd0, K_BRANCH, 7'b0_00_0000, 9'b10_00_000_00, 10'b00000_00000},
    '{8'hE6, 4'd4, 2'd1, K_PLAIN,  7'b0_00_0101, 9'b10_00_011_00, 10'b10000_11000},
    '{8'hEE, 4'd5, 2'd1, K_PLAIN,  7'b0_00_0101, 9'b10_00_011_00, 10'b10000_11000},
    '{8'hC6, 4'd4, 2'd1, K_PLAIN,  7'b0_00_0110, 9'b10_00_011_00, 10'b10000_11000},
    '{8'hCE, 4'd5, 2'd1, K_PLAIN,  7'b0_00_0110, 9'b10_00_011_00, 10'b10000_11000},
    '{8'h06, 4'd4, 2'd1, K_PLAIN,  7'b0_00_0111, 9'b10_10_000_00, 10'b10000_11011},
    '{8'h0E, 4'd5, 2'd1, K_PLAIN,  7'b0_00_0111, 9'b10_10_000_00, 10'b10000_11011},
    '{8'h48, 4'd3, 2'd1, K_PLAIN,  7'b0_00_0010, 9'b10_00_100_00, 10'b00000_00000},
    '{8'h68, 4'd3, 2'd0, K_PLAIN,  7'b1_10_0111, 9'b10_00_000_00, 10'b10000_11000},
    '{8'h18, 4'd1, 2'd0, K_PLAIN,  7'b0_00_0111, 9'b10_00_000_00, 10'b00000_00011},
    '{8'h38, 4'd1, 2'd0, K_PLAIN,  7'b0_00_0111, 9'b10_00_101_01, 10'b00000_00011},
    '{8'hEA, 4'd1, 2'd0, K_PLAIN,  7'b0_00_0000, 9'b10_00_000_00, 10'b00000_00000},
    '{8'hFF, 4'd1, 2'd0, K_PLAIN,  7'b0_00_0000, 9'b10_00_000_00, 10'b00000_00000},
    '{8'h8A, 4'd1, 2'd0, K_PLAIN,  7'b0_00_0000, 9'b10_00_000_00, 10'b00000_00000},
    '{8'h1A, 4'd1, 2'd0, K_PLAIN,  7'b0_00_0000, 9'b10_00_000_00, 10'b00000_00000},
    '{8'h50, 4'd2, 2'd0, K_BRANCH, 7'b0_00_0000, 9'b10_00_000_00, 10'b00000_00000},
    '{8'h70, 4'd2, 2'd0, K_BRANCH, 7'b0_00_0000, 9'b10_00_000_00, 10'b00000_00000},
    '{8'h90, 4'd2, 2'd0, K_BRANCH, 7'b0_00_0000, 9'b10_00_000_00, 10'b00000_00000},
    '{8'hB0, 4'd2, 2'd0, K_BRANCH, 7'b0_00_0000, 9'b10_00_000_00, 10'b00000_00000},
    '{8'hD0, 4'd2, 2'd0, K_BRANCH, 7'b0_00_0000, 9'b10_00_000_00, 10'b00000_00000},
    '{8'hF0, 4'd2, 2'd0, K_BRANCH, 7'b0_00_0000, 9'b10_00_000_00, 10'b00000_00000},
    '{8'h80, 4'd2, 2'd0, K_BRANCH, 7'b0_00_0000, 9'b10_00_000_00, 10'b00000_00000},
    '{8'h4C, 4'd3, 2'd0, K_PLAIN,  7'b0_00_0000, 9'b10_00_000_00, 10'b00000_00000},
    '{8'h6C, 4'd5, 2'd0, K_PLAIN,  7'b0_00_0000, 9'b10_00_000_00, 10'b00000_00000},
    '{8'h20, 4'd5, 2'd2, K_JSR,    7'b0_00_0000, 9'b10_00_000_00, 10'b00000_00000},
    '{8'h60, 4'd4, 2'd0, K_PLAIN,  7'b0_00_0000, 9'b10_00_000_00, 10'b00000_00000},
    '{8'h00, 4'd7, 2'd3, K_BRK,    7'b0_00_0000, 9'b10_00_000_00, 10'b00000_00000},
    '{8'h10, 4'd2, 2'd0, K_BRANCH, 7'b0_00_0000, 9'b10_00_000_00, 10'b00000_00000},
    '{8'h80, 4'd2, 2'd0, K_BRANCH, 7'b0_00_0000, 9'b10_00_000_00, 10'b00000_00000},
    '{8'hF0, 4'd2, 2'd0, K_BRANCH, 7'b0_00_0000, 9'b10_00_000_00, 10'b00000_00000},
    '{8'h20, 4'd5, 2'd2, K_JSR,    7'b0_00_0000, 9'b10_00_000_00, 10'b00000_00000},
    '{8'h00, 4'd7, 2'd3, K_BRK,    7'b0_00_0000, 9'b10_00_000_00, 10'b00000_00000},
    '{8'hA9, 4'd2, 2'd0, K_PLAIN,  7'b1_10_0111, 9'b10_00_000_00, 10'b10000_11000}
};

`endif

//--- tb/cpu_ctl_tb.sv
`default_nettype none

`include "cpu_consts.svh"

module cpu_ctl_tb;

    timeunit 1ns;
    timeprecision 1ps;

    `include "cpu_ctl_vectors.svh"

    logic              clk;
    logic              reset;
    cpu_pkg::opcode_t  db;
    logic              cond;
    logic              sync;
    logic              we;
    cpu_pkg::flag_op_t flag_op;
    cpu_pkg::alu_op_t  alu_op;
    cpu_pkg::reg_op_t  reg_op;
    cpu_pkg::do_sel_t  do_op;
    cpu_pkg::ab_op_t   ab_op;

    logic [31:0] lfsr;
    int          cycle_count = 0;
    int          cycle_limit;

    cpu_ctl DUT (
        .clk     (clk),
        .reset   (reset),
        .db      (db),
        .cond    (cond),
        .sync    (sync),
        .we      (we),
        .flag_op (flag_op),
        .alu_op  (alu_op),
        .reg_op  (reg_op),
        .do_op   (do_op),
        .ab_op   (ab_op)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    function automatic int table_cycles();
        int total;
        total = 0;
        foreach (VECTORS[i]) total += VECTORS[i].cycles;
        return total;
    endfunction

    // Room for the reset entry and the closing sync
    initial begin
        cycle_limit = table_cycles() + 50;
        wait (cycle_count >= cycle_limit);
        $display("Timeout: sync never returned within %0d cycles", cycle_limit);
        $display("TESTS FAILED");
        $fatal(1, "Run stopped by the cycle limit");
    end

    task automatic stop_on_error(input string msg);
        $display("ERR %0t: %s", $time, msg);
        $display("TESTS FAILED");
        $fatal(1, "Run stopped at the first mismatch");
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp) stop_on_error($sformatf("%s: count %0d, expected %0d", what, got, exp));
    endtask

    task automatic check_reg_op(input string what, input cpu_pkg::reg_op_t got,
                                input cpu_pkg::reg_op_t exp);
        if (got !== exp) stop_on_error($sformatf("%s: reg_op %b, expected %b", what, got, exp));
    endtask

    task automatic check_alu_op(input string what, input cpu_pkg::alu_op_t got,
                                input cpu_pkg::alu_op_t exp);
        if (got !== exp) stop_on_error($sformatf("%s: alu_op %b, expected %b", what, got, exp));
    endtask

    task automatic check_flag_op(input string what, input cpu_pkg::flag_op_t got,
                                 input cpu_pkg::flag_op_t exp);
        if (got !== exp) stop_on_error($sformatf("%s: flag_op %b, expected %b", what, got, exp));
    endtask

    task automatic check_ab_op(input string what, input cpu_pkg::ab_op_t got,
                               input cpu_pkg::ab_op_t exp);
        if (got !== exp) stop_on_error($sformatf("%s: ab_op %b, expected %b", what, got, exp));
    endtask

    task automatic check_do_op(input string what, input cpu_pkg::do_sel_t got,
                               input cpu_pkg::do_sel_t exp);
        if (got !== exp) stop_on_error($sformatf("%s: do_op %b, expected %b", what, got, exp));
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32, 22, 2, 1
    endfunction

    task automatic take_bits(input int n, output logic [7:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            bits = {bits[6:0], lfsr[0]};
        end
    endtask

    task automatic drive_operand();
        logic [7:0] bits;
        take_bits(8, bits);
        db = bits;
        take_bits(1, bits);
        cond = bits[0];
    endtask

    task automatic check_sync_ops(input vector_t v);
        string what;
        what = $sformatf("sync after %h", v.op);
        check_reg_op(what, reg_op, v.exp_reg);
        check_alu_op(what, alu_op, v.exp_alu);
        check_flag_op(what, flag_op, v.exp_flag);
    endtask

    // Starts at the falling edge of a sync cycle and returns just after the next sync edge
    task automatic follow_instr(input cpu_pkg::opcode_t op, input kind_t kind,
                                input logic from_reset, output int cycles, output int writes);
        string             what;
        int                offset;
        logic              done;
        logic              back;
        cpu_pkg::ab_mode_t mode;
        cpu_pkg::ab_op_t   ab_exp;
        cpu_pkg::reg_op_t  vec_exp;
        if (from_reset) begin
            what = "reset entry";
        end else begin
            what = $sformatf("opcode %h", op);
        end
        mode = `AB_MODE_BRANCH;
        vec_exp = {3'b000, (from_reset ? `SRC_RST_VEC : `SRC_BRK_VEC)};
        offset = 0;
        writes = 0;
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            #1;
            if (sync) begin
                done = 1'b1;
            end else begin
                drive_operand();
                offset++;
                @(negedge clk);
                if (we) writes++;
                if (kind == K_BRANCH && offset == 1) begin
                    back = cond & db[7];   // Taken with a negative offset
                    ab_exp = {(back ? `AB_OP_HIGH_BACK : `AB_OP_HIGH_BRANCH), mode[1:0],
                              `AB_OP_ABL_AB, mode[2]};
                    check_ab_op({what, " COND"}, ab_op, ab_exp);
                end
                if (kind == K_JSR && offset == 2) check_do_op({what, " JSR1"}, do_op, `DO_PCH);
                if (kind == K_JSR && offset == 3) check_do_op({what, " JSR2"}, do_op, `DO_PCL);
                if (kind == K_BRK && offset == 4) check_reg_op({what, " BRK3"}, reg_op, vec_exp);
            end
        end
        cycles = offset + 1;
    endtask

    initial begin
        vector_t v;
        int      cycles;
        int      writes;
        lfsr = 32'h321faf67;
        reset = 1'b1;
        db = '0;
        cond = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        drive_operand();   // Opcode here is ignored
        @(negedge clk);
        if (!sync) stop_on_error("sync low in the first cycle after reset");
        follow_instr(8'h00, K_BRK, 1'b1, cycles, writes);
        check_count("reset entry cycles", cycles, 7);
        check_count("reset entry writes", writes, 3);
        for (int i = 0; i < NUM_VECTORS; i++) begin
            v = VECTORS[i];
            drive_operand();
            db = v.op;
            @(negedge clk);
            if (i > 0) check_sync_ops(VECTORS[i - 1]);
            follow_instr(v.op, v.kind, 1'b0, cycles, writes);
            check_count($sformatf("opcode %h cycles", v.op), cycles, v.cycles);
            check_count($sformatf("opcode %h writes", v.op), writes, v.writes);
        end
        @(negedge clk);
        check_sync_ops(VECTORS[NUM_VECTORS - 1]);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+rtl
+incdir+tb
rtl/cpu_pkg.sv
rtl/opcode_decode.sv
rtl/exec_fsm.sv
rtl/addr_mode.sv
rtl/micro_ops.sv
rtl/cpu_ctl.sv
tb/cpu_ctl_tb.sv
